//--- design/rtab_config.svh
`ifndef RTAB_CONFIG_SVH
`define RTAB_CONFIG_SVH

// Number of replay table slots
`define RTAB_ENTRIES 8

// Slot index width, wide enough for RTAB_ENTRIES
`define RTAB_PTR_W 3

// Cache-line index width
`define RTAB_NLINE_W 10

// Width of the opaque request payload
`define RTAB_PAYLOAD_W 16

`endif

//--- design/rtab_pkg.sv
`include "rtab_config.svh"

package rtab_pkg;

    typedef logic [`RTAB_PTR_W-1:0]     rtab_ptr_t;
    typedef logic [`RTAB_ENTRIES-1:0]   rtab_vec_t;
    typedef logic [`RTAB_NLINE_W-1:0]   rtab_nline_t;
    typedef logic [`RTAB_PAYLOAD_W-1:0] rtab_payload_t;

    typedef struct packed {
        rtab_nline_t   nline;
        rtab_payload_t payload;
    } rtab_req_t;

    // Pending miss on the line, and miss handler not ready
    typedef struct packed {
        logic mshr_hit;
        logic mshr_not_ready;
    } rtab_deps_t;

    // Per-slot status as seen by the allocator and the pop scheduler
    typedef struct packed {
        logic      valid;
        logic      head;
        logic      tail;
        logic      ready;
        logic      chk_hit;
        logic      chk_tail;
        rtab_ptr_t next;
        logic [2:0] pad;
    } rtab_slot_t;

    typedef enum logic [1:0] {
        POP_HEAD,
        POP_NEXT,
        POP_NEXT_WAIT
    } rtab_pop_state_e;

endpackage

//--- design/rtab_entry.sv
`timescale 1ns/1ps
`include "rtab_config.svh"

module rtab_entry
    import rtab_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        alloc_we_i,
    input  logic        alloc_link_i,
    input  rtab_req_t   alloc_req_i,
    input  rtab_deps_t  alloc_deps_i,
    input  logic        link_we_i,
    input  rtab_ptr_t   alloc_ptr_i,
    input  rtab_nline_t check_nline_i,
    input  logic        refill_i,
    input  rtab_nline_t refill_nline_i,
    input  logic        miss_ready_i,
    input  logic        take_i,
    input  logic        commit_i,
    input  logic        rback_i,
    input  rtab_deps_t  rback_deps_i,
    output rtab_slot_t  slot_o,
    output rtab_req_t   req_o
);

    logic       valid_q;
    logic       head_q;
    logic       tail_q;
    rtab_deps_t deps_q;
    rtab_ptr_t  next_q;
    rtab_req_t  req_q;

    logic       refill_hit;
    logic       chk_hit;

    assign refill_hit = refill_i && (req_q.nline == refill_nline_i);
    assign chk_hit    = valid_q && (req_q.nline == check_nline_i);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
            head_q  <= 1'b0;
            tail_q  <= 1'b0;
            deps_q  <= '0;
            next_q  <= '0;
        end else begin
            if (alloc_we_i) begin
                valid_q <= 1'b1;
            end else if (commit_i) begin
                valid_q <= 1'b0;
            end

            // A linked slot waits for the list walk, a new list starts at its head
            if (alloc_we_i) begin
                head_q <= !alloc_link_i;
            end else if (rback_i) begin
                head_q <= 1'b1;
            end else if (take_i) begin
                head_q <= 1'b0;
            end

            if (alloc_we_i) begin
                tail_q <= 1'b1;
            end else if (link_we_i) begin
                tail_q <= 1'b0;
            end

            if (alloc_we_i) begin
                deps_q <= alloc_deps_i;
            end else if (rback_i) begin
                deps_q <= rback_deps_i;
            end else begin
                if (refill_hit) begin
                    deps_q.mshr_hit <= 1'b0;
                end
                if (miss_ready_i) begin
                    deps_q.mshr_not_ready <= 1'b0;
                end
            end

            if (link_we_i) begin
                next_q <= alloc_ptr_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (alloc_we_i) begin
            req_q <= alloc_req_i;
        end
    end

    // Tail and next already reflect a link made in this cycle, so a walk
    // that takes this slot now continues to the new element
    always_comb begin
        slot_o.valid    = valid_q;
        slot_o.head     = head_q;
        slot_o.tail     = tail_q && !link_we_i;
        slot_o.ready    = valid_q && head_q && !(deps_q.mshr_hit || deps_q.mshr_not_ready);
        slot_o.chk_hit  = chk_hit;
        slot_o.chk_tail = chk_hit && tail_q;
        slot_o.next     = link_we_i ? alloc_ptr_i : next_q;
        slot_o.pad      = '0;
    end

    assign req_o = req_q;

    // Only a slot that was taken earlier may be committed or rolled back
    a_done_on_taken: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (commit_i || rback_i) |-> (valid_q && !head_q))
        else $error("rtab_entry: commit or rollback on a slot that is not in flight");

endmodule

//--- design/rtab_alloc.sv
`timescale 1ns/1ps
`include "rtab_config.svh"

module rtab_alloc
    import rtab_pkg::*;
(
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic                           alloc_i,
    input  logic                           alloc_link_i,
    input  rtab_slot_t [`RTAB_ENTRIES-1:0] slots_i,
    output logic                           check_hit_o,
    output rtab_vec_t                      alloc_we_o,
    output logic                           alloc_link_o,
    output rtab_vec_t                      link_we_o,
    output rtab_ptr_t                      alloc_ptr_o
);

    localparam int N = `RTAB_ENTRIES;

    rtab_vec_t chk_hit;
    rtab_vec_t chk_tail;
    rtab_vec_t free_1h;
    logic      found;
    logic      alloc;

    always_comb begin
        for (int i = 0; i < N; i++) begin
            chk_hit[i]  = slots_i[i].chk_hit;
            chk_tail[i] = slots_i[i].chk_tail;
        end
    end

    // Lowest free slot wins
    always_comb begin
        found       = 1'b0;
        free_1h     = '0;
        alloc_ptr_o = '0;
        for (int i = 0; i < N; i++) begin
            if (!slots_i[i].valid && !found) begin
                found       = 1'b1;
                free_1h[i]  = 1'b1;
                alloc_ptr_o = rtab_ptr_t'(i);
            end
        end
    end

    assign alloc       = alloc_i || alloc_link_i;
    assign check_hit_o = |chk_hit;
    assign alloc_we_o  = free_1h & {N{alloc}};
    assign link_we_o   = chk_tail & {N{alloc_link_i}};

    // Without a tail to hang on, the new slot becomes a head
    assign alloc_link_o = alloc_link_i && (|chk_tail);

    a_tail_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(chk_tail))
        else $error("rtab_alloc: more than one list tail on the checked line");

    a_one_alloc: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(alloc_i && alloc_link_i))
        else $error("rtab_alloc: alloc and alloc_link in the same cycle");

    a_link_hit: assert property (@(posedge clk_i) disable iff (!rst_ni)
        alloc_link_i |-> check_hit_o)
        else $error("rtab_alloc: link without a check hit");

    a_not_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
        alloc |-> found)
        else $error("rtab_alloc: allocation while the table is full");

endmodule

//--- design/rtab_pop.sv
`timescale 1ns/1ps
`include "rtab_config.svh"

module rtab_pop
    import rtab_pkg::*;
(
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  rtab_slot_t [`RTAB_ENTRIES-1:0] slots_i,
    input  rtab_req_t  [`RTAB_ENTRIES-1:0] reqs_i,
    input  logic                           pop_take_i,
    input  logic                           pop_commit_i,
    input  logic                           pop_rback_i,
    input  rtab_ptr_t                      pop_done_ptr_i,
    output logic                           pop_valid_o,
    output rtab_req_t                      pop_req_o,
    output rtab_ptr_t                      pop_ptr_o,
    output rtab_vec_t                      take_o,
    output rtab_vec_t                      commit_o,
    output rtab_vec_t                      rback_o
);

    localparam int N = `RTAB_ENTRIES;

    rtab_pop_state_e state_q;
    rtab_pop_state_e state_d;
    rtab_ptr_t       walk_q;
    rtab_ptr_t       walk_d;
    rtab_ptr_t       rr_q;
    rtab_ptr_t       rr_d;

    rtab_vec_t       ready;
    logic            gnt_any;
    rtab_ptr_t       gnt_ptr;
    rtab_slot_t      sel_slot;
    logic            take_en;

    always_comb begin
        for (int i = 0; i < N; i++) begin
            ready[i] = slots_i[i].ready;
        end
    end

    // Round-robin search over ready heads, starting at rr_q
    always_comb begin : rr_search
        int idx;
        gnt_any = 1'b0;
        gnt_ptr = '0;
        for (int k = 0; k < N; k++) begin
            idx = (int'(rr_q) + k) % N;
            if (!gnt_any && ready[idx]) begin
                gnt_any = 1'b1;
                gnt_ptr = rtab_ptr_t'(idx);
            end
        end
    end

    // Heads are arbitrated, list walks are not
    assign pop_ptr_o   = (state_q == POP_HEAD) ? gnt_ptr : walk_q;
    assign pop_valid_o = (state_q == POP_HEAD) ? gnt_any : 1'b1;
    assign pop_req_o   = reqs_i[pop_ptr_o];
    assign sel_slot    = slots_i[pop_ptr_o];
    assign take_en     = pop_take_i && pop_valid_o && !pop_rback_i;

    always_comb begin
        state_d = state_q;
        walk_d  = walk_q;
        case (state_q)
            POP_HEAD: begin
                if (take_en && !sel_slot.tail) begin
                    state_d = POP_NEXT;
                    walk_d  = sel_slot.next;
                end
            end
            POP_NEXT: begin
                // The previous element came back, drop the rest of this walk
                if (pop_rback_i) begin
                    state_d = POP_HEAD;
                end else if (take_en) begin
                    if (!sel_slot.tail) begin
                        walk_d = sel_slot.next;
                    end else begin
                        state_d = POP_HEAD;
                    end
                end else begin
                    state_d = POP_NEXT_WAIT;
                end
            end
            POP_NEXT_WAIT: begin
                if (take_en) begin
                    if (!sel_slot.tail) begin
                        state_d = POP_NEXT;
                        walk_d  = sel_slot.next;
                    end else begin
                        state_d = POP_HEAD;
                    end
                end
            end
            default: begin
                state_d = POP_HEAD;
            end
        endcase
    end

    // Park the priority on an unaccepted head so the offer holds, move past it once taken
    always_comb begin
        rr_d = rr_q;
        if (state_q == POP_HEAD && gnt_any) begin
            if (!take_en) begin
                rr_d = gnt_ptr;
            end else if (gnt_ptr == rtab_ptr_t'(N - 1)) begin
                rr_d = '0;
            end else begin
                rr_d = gnt_ptr + rtab_ptr_t'(1);
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= POP_HEAD;
            walk_q  <= '0;
            rr_q    <= '0;
        end else begin
            state_q <= state_d;
            walk_q  <= walk_d;
            rr_q    <= rr_d;
        end
    end

    always_comb begin
        for (int i = 0; i < N; i++) begin
            take_o[i]   = take_en && (pop_ptr_o == rtab_ptr_t'(i));
            commit_o[i] = pop_commit_i && (pop_done_ptr_i == rtab_ptr_t'(i));
            rback_o[i]  = pop_rback_i && (pop_done_ptr_i == rtab_ptr_t'(i));
        end
    end

    a_rback_no_take: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_rback_i |-> !pop_take_i)
        else $error("rtab_pop: take during a rollback");

    a_take_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
        take_en |=> (pop_commit_i || pop_rback_i) && (pop_done_ptr_i == $past(pop_ptr_o)))
        else $error("rtab_pop: accepted request not committed or rolled back next cycle");

endmodule

//--- design/rtab_top.sv
`timescale 1ns/1ps
`include "rtab_config.svh"

module rtab_top
    import rtab_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_ni,

    input  logic        check_i,
    input  rtab_nline_t check_nline_i,
    output logic        check_hit_o,

    input  logic        alloc_i,
    input  logic        alloc_link_i,
    input  rtab_req_t   alloc_req_i,
    input  rtab_deps_t  alloc_deps_i,

    output logic        pop_valid_o,
    output rtab_req_t   pop_req_o,
    output rtab_ptr_t   pop_ptr_o,
    input  logic        pop_take_i,
    input  logic        pop_commit_i,
    input  logic        pop_rback_i,
    input  rtab_ptr_t   pop_done_ptr_i,
    input  rtab_deps_t  pop_rback_deps_i,

    input  logic        refill_i,
    input  rtab_nline_t refill_nline_i,
    input  logic        miss_ready_i,

    output logic        empty_o,
    output logic        full_o
);

    localparam int N = `RTAB_ENTRIES;

    rtab_slot_t [N-1:0] slots;
    rtab_req_t  [N-1:0] reqs;
    rtab_vec_t          valid;
    rtab_vec_t          alloc_we;
    rtab_vec_t          link_we;
    rtab_vec_t          take;
    rtab_vec_t          commit;
    rtab_vec_t          rback;
    rtab_ptr_t          alloc_ptr;
    logic               alloc_link;
    logic               entry_link;
    logic               chk_hit_any;

    rtab_alloc u_alloc (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .alloc_i      (alloc_i),
        .alloc_link_i (alloc_link_i),
        .slots_i      (slots),
        .check_hit_o  (chk_hit_any),
        .alloc_we_o   (alloc_we),
        .alloc_link_o (alloc_link),
        .link_we_o    (link_we),
        .alloc_ptr_o  (alloc_ptr)
    );

    // A tail committed in this very cycle leaves no list behind,
    // so the new slot has to start its own
    assign entry_link = alloc_link && !(|(link_we & commit));

    for (genvar i = 0; i < N; i++) begin : gen_entry
        rtab_entry u_entry (
            .clk_i          (clk_i),
            .rst_ni         (rst_ni),
            .alloc_we_i     (alloc_we[i]),
            .alloc_link_i   (entry_link),
            .alloc_req_i    (alloc_req_i),
            .alloc_deps_i   (alloc_deps_i),
            .link_we_i      (link_we[i]),
            .alloc_ptr_i    (alloc_ptr),
            .check_nline_i  (check_nline_i),
            .refill_i       (refill_i),
            .refill_nline_i (refill_nline_i),
            .miss_ready_i   (miss_ready_i),
            .take_i         (take[i]),
            .commit_i       (commit[i]),
            .rback_i        (rback[i]),
            .rback_deps_i   (pop_rback_deps_i),
            .slot_o         (slots[i]),
            .req_o          (reqs[i])
        );

        assign valid[i] = slots[i].valid;
    end

    rtab_pop u_pop (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .slots_i        (slots),
        .reqs_i         (reqs),
        .pop_take_i     (pop_take_i),
        .pop_commit_i   (pop_commit_i),
        .pop_rback_i    (pop_rback_i),
        .pop_done_ptr_i (pop_done_ptr_i),
        .pop_valid_o    (pop_valid_o),
        .pop_req_o      (pop_req_o),
        .pop_ptr_o      (pop_ptr_o),
        .take_o         (take),
        .commit_o       (commit),
        .rback_o        (rback)
    );

    // Hit only reported for an active check
    assign check_hit_o = check_i && chk_hit_any;

    assign empty_o = ~(|valid);
    assign full_o  = &valid;

endmodule

//--- test/tb_rtab.sv
`timescale 1ns/1ps
`include "rtab_config.svh"

module tb_rtab
    import rtab_pkg::*;
();

    localparam int N           = `RTAB_ENTRIES;
    localparam int CLK_PERIOD  = 20;
    localparam int RAND_CYCLES = 600;
    localparam int NUM_OPS     = N + RAND_CYCLES;
    localparam int TIMEOUT_NS  = NUM_OPS * 40 * CLK_PERIOD;
    localparam int NLINES      = 4;

    // Model element in allocation order
    typedef struct packed {
        rtab_nline_t   nline;
        rtab_payload_t payload;
        rtab_deps_t    deps;
        logic          inflight;
        rtab_ptr_t     slot;
    } model_entry_t;

    logic          clk_i;
    logic          rst_ni;
    logic          check_i;
    rtab_nline_t   check_nline_i;
    logic          check_hit_o;
    logic          alloc_i;
    logic          alloc_link_i;
    rtab_req_t     alloc_req_i;
    rtab_deps_t    alloc_deps_i;
    logic          pop_valid_o;
    rtab_req_t     pop_req_o;
    rtab_ptr_t     pop_ptr_o;
    logic          pop_take_i;
    logic          pop_commit_i;
    logic          pop_rback_i;
    rtab_ptr_t     pop_done_ptr_i;
    rtab_deps_t    pop_rback_deps_i;
    logic          refill_i;
    rtab_nline_t   refill_nline_i;
    logic          miss_ready_i;
    logic          empty_o;
    logic          full_o;

    model_entry_t  model_q[$];
    rtab_nline_t   lines[NLINES];
    rtab_nline_t   unused_line;
    rtab_payload_t next_payload;
    rtab_payload_t flight_payload;
    logic          acc_pend;
    rtab_ptr_t     acc_ptr;
    logic          held_q;
    rtab_req_t     held_req;
    rtab_ptr_t     held_ptr;
    int            mismatch_cnt;
    int            fail_cnt;

    rtab_top dut_i (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    function automatic int oldest_index(rtab_nline_t nline);
        for (int i = 0; i < model_q.size(); i++) begin
            if (model_q[i].nline == nline) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic int find_payload(rtab_payload_t payload);
        for (int i = 0; i < model_q.size(); i++) begin
            if (model_q[i].payload == payload) begin
                return i;
            end
        end
        return -1;
    endfunction

    // Allocation takes the lowest slot not held by a live request
    function automatic int lowest_free_slot();
        logic used;
        for (int s = 0; s < N; s++) begin
            used = 1'b0;
            for (int i = 0; i < model_q.size(); i++) begin
                if (model_q[i].slot == rtab_ptr_t'(s)) begin
                    used = 1'b1;
                end
            end
            if (!used) begin
                return s;
            end
        end
        return -1;
    endfunction

    // Only the oldest live request of a line may leave, and only when idle with clear deps
    function automatic logic may_accept(rtab_nline_t nline, rtab_payload_t payload);
        int idx;
        idx = oldest_index(nline);
        if (idx < 0) begin
            return 1'b0;
        end
        return (model_q[idx].payload == payload) && !model_q[idx].inflight &&
               !model_q[idx].deps.mshr_hit && !model_q[idx].deps.mshr_not_ready;
    endfunction

    function automatic rtab_deps_t random_deps(int pct);
        rtab_deps_t d;
        d.mshr_hit       = ($urandom % 100) < pct;
        d.mshr_not_ready = ($urandom % 100) < pct;
        return d;
    endfunction

    task automatic flag_mismatch(string sig, logic [31:0] got, logic [31:0] exp);
        $display("MISMATCH at %0t: %s got 0x%0h expected 0x%0h", $time, sig, got, exp);
        mismatch_cnt++;
    endtask

    task automatic note_failure(string what);
        $display("ERROR at %0t: %s", $time, what);
        fail_cnt++;
    endtask

    task automatic explain_bad_accept(rtab_req_t req);
        int idx;
        idx = oldest_index(req.nline);
        if (idx < 0) begin
            note_failure($sformatf("request 0x%0h accepted for line 0x%0h with no live entry",
                                   req.payload, req.nline));
        end else if (model_q[idx].payload == req.payload) begin
            note_failure($sformatf("request 0x%0h accepted while in flight or waiting on deps",
                                   req.payload));
        end else begin
            flag_mismatch("pop_req_o.payload", req.payload, model_q[idx].payload);
        end
    endtask

    // Drives one clock of stimulus with percentages that steer the random choices
    task automatic drive_cycle(input int alloc_pct, input int take_pct, input int rback_pct,
                               input int event_pct);
        int   li;
        logic rb;
        @(posedge clk_i);
        #1;
        rb               = 1'b0;
        pop_commit_i     = 1'b0;
        pop_rback_i      = 1'b0;
        pop_rback_deps_i = '0;
        // Answer the accept of the previous cycle
        if (acc_pend) begin
            rb             = ($urandom % 100) < rback_pct;
            pop_done_ptr_i = acc_ptr;
            pop_commit_i   = !rb;
            pop_rback_i    = rb;
            if (rb) begin
                pop_rback_deps_i = random_deps(30);
            end
        end
        pop_take_i = !rb && (($urandom % 100) < take_pct);

        alloc_i       = 1'b0;
        alloc_link_i  = 1'b0;
        alloc_deps_i  = '0;
        li            = $urandom % (NLINES + 1);
        check_i       = ($urandom % 2) == 1;
        check_nline_i = (li == NLINES) ? unused_line : lines[li];
        if (model_q.size() < N && ($urandom % 100) < alloc_pct) begin
            li                  = $urandom % NLINES;
            check_i             = 1'b1;
            check_nline_i       = lines[li];
            alloc_req_i.nline   = lines[li];
            alloc_req_i.payload = next_payload;
            next_payload++;
            // Linked requests enter without deps since only list heads wait on them
            if (oldest_index(lines[li]) >= 0) begin
                alloc_link_i = 1'b1;
            end else begin
                alloc_i      = 1'b1;
                alloc_deps_i = random_deps(30);
            end
        end
        refill_i       = ($urandom % 100) < event_pct;
        refill_nline_i = lines[$urandom % NLINES];
        miss_ready_i   = ($urandom % 100) < event_pct;
    endtask

    // Compare outputs mid-cycle and then apply this cycle's events to the model
    always @(negedge clk_i) begin : compare
        int           idx;
        int           rb_idx;
        int           alloc_slot;
        logic         take_en;
        model_entry_t ent;
        if (rst_ni) begin
            assert (empty_o == (model_q.size() == 0))
                else flag_mismatch("empty_o", empty_o, model_q.size() == 0);
            assert (full_o == (model_q.size() == N))
                else flag_mismatch("full_o", full_o, model_q.size() == N);
            assert (check_hit_o == (check_i && oldest_index(check_nline_i) >= 0))
                else flag_mismatch("check_hit_o", check_hit_o,
                                   check_i && oldest_index(check_nline_i) >= 0);

            // An offer left untaken must stay put unless a rollback ends the list walk
            if (held_q) begin
                assert (pop_valid_o)
                    else note_failure("offer withdrawn while pop_take_i was low");
                assert (!pop_valid_o || pop_req_o == held_req)
                    else flag_mismatch("pop_req_o", pop_req_o, held_req);
                assert (!pop_valid_o || pop_ptr_o == held_ptr)
                    else flag_mismatch("pop_ptr_o", pop_ptr_o, held_ptr);
            end
            held_q   = pop_valid_o && !pop_take_i && !pop_rback_i;
            held_req = pop_req_o;
            held_ptr = pop_ptr_o;

            // A slot committed in this cycle is still occupied for this allocation
            alloc_slot = lowest_free_slot();

            rb_idx = -1;
            if (pop_commit_i || pop_rback_i) begin
                idx = find_payload(flight_payload);
                if (idx >= 0 && pop_commit_i) begin
                    model_q.delete(idx);
                end else if (idx >= 0) begin
                    model_q[idx].inflight = 1'b0;
                    rb_idx = idx;
                end
            end

            take_en  = pop_take_i && pop_valid_o && !pop_rback_i;
            acc_pend = take_en;
            if (take_en) begin
                assert (may_accept(pop_req_o.nline, pop_req_o.payload))
                    else explain_bad_accept(pop_req_o);
                idx = find_payload(pop_req_o.payload);
                if (idx >= 0) begin
                    assert (pop_ptr_o == model_q[idx].slot)
                        else flag_mismatch("pop_ptr_o", pop_ptr_o, model_q[idx].slot);
                    model_q[idx].inflight = 1'b1;
                end
                acc_ptr        = pop_ptr_o;
                flight_payload = pop_req_o.payload;
            end

            for (int i = 0; i < model_q.size(); i++) begin
                if (refill_i && model_q[i].nline == refill_nline_i) begin
                    model_q[i].deps.mshr_hit = 1'b0;
                end
                if (miss_ready_i) begin
                    model_q[i].deps.mshr_not_ready = 1'b0;
                end
            end
            // Rollback deps replace whatever cleared in the same cycle
            if (rb_idx >= 0) begin
                model_q[rb_idx].deps = pop_rback_deps_i;
            end

            if (alloc_i || alloc_link_i) begin
                ent.nline    = alloc_req_i.nline;
                ent.payload  = alloc_req_i.payload;
                ent.deps     = alloc_deps_i;
                ent.inflight = 1'b0;
                ent.slot     = rtab_ptr_t'(alloc_slot);
                model_q.push_back(ent);
            end
        end
    end

    initial begin : stimulus
        int base;
        void'($urandom(88439));
        clk_i            = 1'b0;
        rst_ni           = 1'b0;
        check_i          = 1'b0;
        check_nline_i    = '0;
        alloc_i          = 1'b0;
        alloc_link_i     = 1'b0;
        alloc_req_i      = '0;
        alloc_deps_i     = '0;
        pop_take_i       = 1'b0;
        pop_commit_i     = 1'b0;
        pop_rback_i      = 1'b0;
        pop_done_ptr_i   = '0;
        pop_rback_deps_i = '0;
        refill_i         = 1'b0;
        refill_nline_i   = '0;
        miss_ready_i     = 1'b0;
        next_payload     = 16'h0001;
        flight_payload   = '0;
        acc_pend         = 1'b0;
        acc_ptr          = '0;
        held_q           = 1'b0;
        held_req         = '0;
        held_ptr         = '0;
        mismatch_cnt     = 0;
        fail_cnt         = 0;

        // Four distinct lines in use and one more that never gets allocated
        base = $urandom % 1024;
        for (int i = 0; i < NLINES; i++) begin
            lines[i] = rtab_nline_t'(base + i * 97);
        end
        unused_line = rtab_nline_t'(base + 512);

        repeat (5) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        @(negedge clk_i);
        assert (empty_o && !full_o && !pop_valid_o && !check_hit_o)
            else note_failure("outputs not idle after reset");

        repeat (N) drive_cycle(100, 0, 0, 0);
        drive_cycle(0, 0, 0, 0);
        @(negedge clk_i);
        assert (full_o) else note_failure("full_o low with every slot allocated");

        repeat (RAND_CYCLES) drive_cycle(40, 60, 25, 20);

        // Drain by accepting and committing everything while deps clear every cycle
        while (model_q.size() > 0 || acc_pend) begin
            drive_cycle(0, 100, 0, 100);
        end
        drive_cycle(0, 0, 0, 0);
        @(negedge clk_i);
        assert (empty_o) else note_failure("empty_o low after every entry was committed");

        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("ERROR at %0t: watchdog expired before the table drained", $time);
        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt + 1);
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- sim.f
+incdir+design
design/rtab_pkg.sv
design/rtab_entry.sv
design/rtab_alloc.sv
design/rtab_pop.sv
design/rtab_top.sv
test/tb_rtab.sv

//--- Makefile
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f sim.f \
		--top-module tb_rtab -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/Vtb_rtab | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "Run failed"; exit 1; \
	fi
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
